//--- design/fe_pkg.sv
package fe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Pc width, fixed by the instruction format
    localparam int ADDR_W = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction classes
    ////////////////////////////////////////////////////////////////////////////

    // Decoded from instr[15:11]
    typedef enum logic [4:0] {
        // Unconditional jump, 11-bit signed offset in [10:0]
        OP_JUMP   = 5'b00010,
        // Conditional branch, 8-bit signed offset in [7:0]
        OP_BRANCH = 5'b00011,
        // Anything else, front end treats it as sequential
        OP_OTHER  = 5'b11111
    } op_class_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////////////

    // Registered fetch result towards decode, 49 bits
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] pcplus1;
        logic [15:0]       instr;
    } fetch_out_t;

    // Execute verdict on the oldest tracked branch
    typedef struct packed {
        // One cycle per resolved branch
        logic strobe;
        // Set when the branch was mispredicted, i.e. taken
        logic taken;
    } resolve_t;

endpackage

//--- design/instr_mem.sv
module instr_mem #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                      CLK,
    input  logic                      load_we_i,
    input  logic [fe_pkg::ADDR_W-1:0] load_addr_i,
    input  logic [15:0]               load_data_i,
    input  logic [fe_pkg::ADDR_W-1:0] rd_addr_i,
    output logic [15:0]               rd_data_o
);

    // Index width, MEM_DEPTH is a power of two
    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    // Word storage, contents come from the load port only
    logic [15:0] mem [MEM_DEPTH];

    // Address modulo MEM_DEPTH
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    assign wr_idx = load_addr_i[IDX_W-1:0];
    assign rd_idx = rd_addr_i[IDX_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Load port
    ////////////////////////////////////////////////////////////////////////////

    // Program load while fetch is stalled
    always_ff @(posedge CLK) begin
        if (load_we_i) begin
            mem[wr_idx] <= load_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////////////////////////////////////////

    // Same cycle read for the current pc
    assign rd_data_o = mem[rd_idx];

endmodule

//--- design/branch_tracker.sv
module branch_tracker #(
    parameter int TRACK_DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      push_i,
    input  logic [fe_pkg::ADDR_W-1:0] push_target_i,
    input  fe_pkg::resolve_t          resolve_i,
    input  logic                      flush_i,
    output logic                      full_o,
    output logic                      empty_o,
    output logic [fe_pkg::ADDR_W-1:0] head_target_o
);

    localparam int PTR_W = (TRACK_DEPTH > 1) ? $clog2(TRACK_DEPTH) : 1;
    localparam int CNT_W = $clog2(TRACK_DEPTH + 1);

    // Occupancy state
    typedef enum logic [1:0] {
        EMPTY,
        PARTIAL,
        FULL
    } state_e;

    state_e state;
    state_e state_nxt;

    // Targets of branches predicted not taken, oldest at rd_ptr
    logic [fe_pkg::ADDR_W-1:0] targets [TRACK_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;

    logic pop;
    logic clear;
    logic push_ok;

    // Circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(TRACK_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Queue control
    ////////////////////////////////////////////////////////////////////////////

    // Register jump or taken branch, younger entries are wrong path
    assign clear = flush_i | (resolve_i.strobe & resolve_i.taken);

    // Resolve always retires the oldest entry
    assign pop = resolve_i.strobe & (state != EMPTY);

    // Full queue still takes a push when a pop frees a slot
    // Push in a clearing cycle belongs to a squashed word
    assign push_ok = push_i & ~clear & ((state != FULL) | pop);

    always_comb begin
        if (clear) begin
            count_nxt = '0;
        end else begin
            count_nxt = count + CNT_W'(push_ok) - CNT_W'(pop);
        end
    end

    always_comb begin
        if (count_nxt == '0) begin
            state_nxt = EMPTY;
        end else if (count_nxt == CNT_W'(TRACK_DEPTH)) begin
            state_nxt = FULL;
        end else begin
            state_nxt = PARTIAL;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state  <= EMPTY;
            count  <= '0;
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            state <= state_nxt;
            count <= count_nxt;
            if (clear) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (pop) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                if (push_ok) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
            end
        end
    end

    // Target storage
    always_ff @(posedge CLK) begin
        if (push_ok) begin
            targets[wr_ptr] <= push_target_i;
        end
    end

    // Status and head
    assign full_o        = (state == FULL);
    assign empty_o       = (state == EMPTY);
    assign head_target_o = targets[rd_ptr];

endmodule

//--- design/ifetch.sv
module ifetch (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      stall_i,
    input  logic                      jr_valid_i,
    input  logic [fe_pkg::ADDR_W-1:0] jr_addr_i,
    input  fe_pkg::resolve_t          resolve_i,
    input  logic [15:0]               instr_i,
    input  logic                      track_full_i,
    input  logic [fe_pkg::ADDR_W-1:0] track_head_i,
    output logic [fe_pkg::ADDR_W-1:0] pc_o,
    output logic                      push_o,
    output logic [fe_pkg::ADDR_W-1:0] push_target_o,
    output logic                      flush_o,
    output fe_pkg::fetch_out_t        fetch_o
);

    // Program counter and post-reset start flag
    logic [fe_pkg::ADDR_W-1:0] pc;
    logic                      post_reset;

    // Decode of the current word
    fe_pkg::op_class_e         op_class;
    logic [fe_pkg::ADDR_W-1:0] offset;
    logic [fe_pkg::ADDR_W-1:0] pcplus1;
    logic [fe_pkg::ADDR_W-1:0] pcplusoff;

    // Redirect and hold terms
    logic                      taken_redirect;
    logic                      ext_redirect;
    logic                      track_hold;
    logic                      hold;
    logic                      accept;
    logic [fe_pkg::ADDR_W-1:0] pc_nxt;

    // Fetch output register
    logic                      fetch_valid;
    logic [fe_pkg::ADDR_W-1:0] fetch_pc;
    logic [fe_pkg::ADDR_W-1:0] fetch_pcplus1;
    logic [15:0]               fetch_instr;

    ////////////////////////////////////////////////////////////////////////////
    // Classify and target
    ////////////////////////////////////////////////////////////////////////////

    // Class from the top five bits
    always_comb begin
        case (instr_i[15:11])
            fe_pkg::OP_JUMP:   op_class = fe_pkg::OP_JUMP;
            fe_pkg::OP_BRANCH: op_class = fe_pkg::OP_BRANCH;
            default:           op_class = fe_pkg::OP_OTHER;
        endcase
    end

    // Jump uses 11 offset bits, everything else 8
    always_comb begin
        if (op_class == fe_pkg::OP_JUMP) begin
            offset = {{(fe_pkg::ADDR_W - 11){instr_i[10]}}, instr_i[10:0]};
        end else begin
            offset = {{(fe_pkg::ADDR_W - 8){instr_i[7]}}, instr_i[7:0]};
        end
    end

    // Relative to the next sequential pc
    assign pcplus1   = pc + 1'b1;
    assign pcplusoff = pcplus1 + offset;

    ////////////////////////////////////////////////////////////////////////////
    // Next pc selection
    ////////////////////////////////////////////////////////////////////////////

    // Only a taken resolve redirects, not taken just pops
    assign taken_redirect = resolve_i.strobe & resolve_i.taken;
    assign ext_redirect   = jr_valid_i | taken_redirect;

    // Branch with nowhere to park its target
    // A same-cycle resolve frees a slot
    assign track_hold = (op_class == fe_pkg::OP_BRANCH) & track_full_i & ~resolve_i.strobe;
    assign hold       = stall_i | track_hold;

    // Current word goes to decode
    assign accept = ~post_reset & ~hold & ~ext_redirect;

    // jr, then taken resolve, then own jump, then sequential
    always_comb begin
        if (post_reset) begin
            pc_nxt = '0;
        end else if (jr_valid_i) begin
            pc_nxt = jr_addr_i;
        end else if (taken_redirect) begin
            pc_nxt = track_head_i;
        end else if (hold) begin
            pc_nxt = pc;
        end else if (op_class == fe_pkg::OP_JUMP) begin
            pc_nxt = pcplusoff;
        end else begin
            pc_nxt = pcplus1;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            post_reset  <= 1'b1;
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            // Start cycle waits for the first unstalled edge
            if (!stall_i) begin
                post_reset <= 1'b0;
            end
            pc          <= pc_nxt;
            fetch_valid <= accept;
        end
    end

    // Payload only moves with an accepted word
    always_ff @(posedge CLK) begin
        if (accept) begin
            fetch_pc      <= pc;
            fetch_pcplus1 <= pcplus1;
            fetch_instr   <= instr_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    assign pc_o = pc;

    // Predicted not taken, remember where it would have gone
    assign push_o        = accept & (op_class == fe_pkg::OP_BRANCH);
    assign push_target_o = pcplusoff;

    // Register jump discards every branch in flight
    assign flush_o = jr_valid_i & ~post_reset;

    assign fetch_o = '{
        valid:   fetch_valid,
        pc:      fetch_pc,
        pcplus1: fetch_pcplus1,
        instr:   fetch_instr
    };

endmodule

//--- design/fetch_frontend.sv
module fetch_frontend #(
    parameter int MEM_DEPTH   = 256,
    parameter int TRACK_DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      stall_i,
    input  logic                      jr_valid_i,
    input  logic [fe_pkg::ADDR_W-1:0] jr_addr_i,
    input  fe_pkg::resolve_t          resolve_i,
    input  logic                      load_we_i,
    input  logic [fe_pkg::ADDR_W-1:0] load_addr_i,
    input  logic [15:0]               load_data_i,
    output fe_pkg::fetch_out_t        fetch_o
);

    // Fetch address and returned word
    logic [fe_pkg::ADDR_W-1:0] pc;
    logic [15:0]               instr;

    // Tracker interface
    logic                      push;
    logic [fe_pkg::ADDR_W-1:0] push_target;
    logic                      flush;
    logic                      track_full;
    logic [fe_pkg::ADDR_W-1:0] track_head;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction memory
    ////////////////////////////////////////////////////////////////////////////

    instr_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_instr_mem (
        .CLK         (CLK),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .rd_addr_i   (pc),
        .rd_data_o   (instr)
    );

    // Pc, redirects and fetch register
    ifetch u_ifetch (
        .CLK           (CLK),
        .RST           (RST),
        .stall_i       (stall_i),
        .jr_valid_i    (jr_valid_i),
        .jr_addr_i     (jr_addr_i),
        .resolve_i     (resolve_i),
        .instr_i       (instr),
        .track_full_i  (track_full),
        .track_head_i  (track_head),
        .pc_o          (pc),
        .push_o        (push),
        .push_target_o (push_target),
        .flush_o       (flush),
        .fetch_o       (fetch_o)
    );

    // Outstanding branch targets
    branch_tracker #(
        .TRACK_DEPTH (TRACK_DEPTH)
    ) u_branch_tracker (
        .CLK           (CLK),
        .RST           (RST),
        .push_i        (push),
        .push_target_i (push_target),
        .resolve_i     (resolve_i),
        .flush_i       (flush),
        .full_o        (track_full),
        // Fetch only needs full
        .empty_o       (),
        .head_target_o (track_head)
    );

endmodule

//--- verification/fetch_frontend_sva.sv
module fetch_frontend_sva (
    input logic                      CLK,
    input logic                      RST,
    input logic                      resolve_strobe_i,
    input logic                      empty_i,
    input logic                      push_req_i,
    input logic                      full_i,
    input logic                      pop_i,
    input logic                      stall_i,
    input logic                      redirect_i,
    input logic [fe_pkg::ADDR_W-1:0] pc_i
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////////////////////
    // Tracker occupancy
    ////////////////////////////////////////////////////////////////////////////

    // Resolve only with a branch in flight
    no_pop_empty: assert property (@(posedge CLK) disable iff (RST)
        resolve_strobe_i |-> !empty_i)
        else $error("resolve strobe while tracker empty");

    // Push request into a full queue only alongside a pop
    no_push_full: assert property (@(posedge CLK) disable iff (RST)
        (push_req_i && full_i) |-> pop_i)
        else $error("push into full tracker without pop");

    // Pc held under stall unless jr or taken resolve
    pc_held_stall: assert property (@(posedge CLK) disable iff (RST)
        (stall_i && !redirect_i) |=> (pc_i == $past(pc_i)))
        else $error("pc moved under stall without redirect");

endmodule

bind branch_tracker fetch_frontend_sva u_tracker_sva (
    .CLK (CLK), .RST (RST), .resolve_strobe_i (resolve_i.strobe), .empty_i (empty_o),
    .push_req_i (push_i), .full_i (full_o), .pop_i (pop),
    .stall_i (1'b0), .redirect_i (1'b0), .pc_i ('0)
);

bind ifetch fetch_frontend_sva u_ifetch_sva (
    .CLK (CLK), .RST (RST), .resolve_strobe_i (1'b0), .empty_i (1'b0),
    .push_req_i (1'b0), .full_i (1'b0), .pop_i (1'b0),
    .stall_i (stall_i), .redirect_i (ext_redirect), .pc_i (pc)
);

//--- verification/fetch_frontend_tb.sv
module fetch_frontend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_DEPTH   = 256;
    localparam int TRACK_DEPTH = 4;
    localparam int IDX_W       = $clog2(MEM_DEPTH);
    localparam int RUN_CYCLES  = 4000;
    // Reset, program load, run, then twice that as margin
    localparam int TIMEOUT_CYCLES = 2 * (2 + MEM_DEPTH + 1 + RUN_CYCLES + 1);

    logic                      CLK = 1'b0;
    logic                      RST;
    logic                      stall;
    logic                      jr_valid;
    logic [fe_pkg::ADDR_W-1:0] jr_addr;
    fe_pkg::resolve_t          resolve;
    logic                      load_we;
    logic [fe_pkg::ADDR_W-1:0] load_addr;
    logic [15:0]               load_data;
    fe_pkg::fetch_out_t        fetch_out;

    // Program image as loaded into the DUT
    logic [15:0] prog [MEM_DEPTH];
    logic [31:0] lfsr_state;

    // Reference model state
    logic [15:0] m_pc;
    logic        m_start;
    logic [15:0] m_q [$];
    logic        exp_valid;
    logic [15:0] exp_pc;
    logic [15:0] exp_pcplus1;
    logic [15:0] exp_instr;

    // Inputs the DUT samples on the coming edge
    logic        cur_stall;
    logic        cur_jr;
    logic [15:0] cur_jr_addr;
    logic        cur_strobe;
    logic        cur_taken;

    // Event counts
    int n_full_hold = 0;
    int n_taken     = 0;
    int n_jr_taken  = 0;
    int n_jump      = 0;
    int cycle_count = 0;

    fetch_frontend #(
        .MEM_DEPTH   (MEM_DEPTH),
        .TRACK_DEPTH (TRACK_DEPTH)
    ) dut0 (
        .CLK         (CLK),
        .RST         (RST),
        .stall_i     (stall),
        .jr_valid_i  (jr_valid),
        .jr_addr_i   (jr_addr),
        .resolve_i   (resolve),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .fetch_o     (fetch_out)
    );

    always #5 CLK = ~CLK;

    // Hang guard
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////

    // Galois form with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One step per bit taken from the state lsb
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // Roughly 20% branch, 5% jump, rest other
    function automatic logic [15:0] make_word();
        logic [31:0] sel;
        logic [31:0] bits;
        logic [15:0] w;
        sel = rand_bits(6);
        if (sel < 32'd13) begin
            bits = rand_bits(11);
            w    = {5'b00011, bits[10:0]};
        end else if (sel < 32'd16) begin
            bits = rand_bits(11);
            w    = {5'b00010, bits[10:0]};
        end else begin
            bits = rand_bits(16);
            w    = bits[15:0];
            // Keep other words out of the jump and branch codes
            if (w[15:12] == 4'b0001) begin
                w[15] = 1'b1;
            end
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Payload only matters on a valid fetch
    task automatic compare_fetch();
        check_value(32'(fetch_out.valid), 32'(exp_valid), "fetch valid");
        if (exp_valid) begin
            check_value(32'(fetch_out.pc), 32'(exp_pc), "fetch pc");
            check_value(32'(fetch_out.pcplus1), 32'(exp_pcplus1), "fetch pcplus1");
            check_value(32'(fetch_out.instr), 32'(exp_instr), "fetch instr");
        end
    endtask

    // Advance one edge with the cur_* inputs
    task automatic model_step();
        logic [15:0] word;
        logic [15:0] head;
        logic        is_branch;
        logic        is_jump;
        logic        taken;
        logic        hold;
        logic        accept;
        word      = prog[m_pc[IDX_W-1:0]];
        is_branch = (word[15:11] == 5'b00011);
        is_jump   = (word[15:11] == 5'b00010);
        head      = (m_q.size() > 0) ? m_q[0] : 16'h0000;
        if (m_start) begin
            // Pc pinned at 0 until stall drops
            exp_valid = 1'b0;
            m_pc      = '0;
            m_start   = cur_stall;
        end else begin
            taken  = cur_strobe & cur_taken;
            hold   = cur_stall | (is_branch & (m_q.size() == TRACK_DEPTH) & ~cur_strobe);
            accept = ~hold & ~cur_jr & ~taken;
            if (is_branch && m_q.size() == TRACK_DEPTH && !cur_strobe && !cur_stall) begin
                n_full_hold++;
            end
            if (taken) begin
                n_taken++;
            end
            if (taken && cur_jr) begin
                n_jr_taken++;
            end
            if (accept && is_jump) begin
                n_jump++;
            end
            exp_valid   = accept;
            exp_pc      = m_pc;
            exp_pcplus1 = m_pc + 16'd1;
            exp_instr   = word;
            // Outside redirect drops the younger wrong-path branches
            if (cur_jr || taken) begin
                m_q.delete();
            end else begin
                if (cur_strobe && m_q.size() > 0) begin
                    m_q.delete(0);
                end
                if (accept && is_branch) begin
                    m_q.push_back(m_pc + 16'd1 + {{8{word[7]}}, word[7:0]});
                end
            end
            // jr, taken, hold, own jump, sequential
            if (cur_jr) begin
                m_pc = cur_jr_addr;
            end else if (taken) begin
                m_pc = head;
            end else if (!hold) begin
                if (is_jump) begin
                    m_pc = m_pc + 16'd1 + {{5{word[10]}}, word[10:0]};
                end else begin
                    m_pc = m_pc + 16'd1;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Quiet phases let the tracker fill up
    task automatic pick_stimulus(input int cyc);
        logic quiet;
        quiet       = ((cyc / 64) % 2) == 1;
        cur_stall   = (rand_bits(3) == 32'd0);
        cur_jr      = quiet ? (rand_bits(6) == 32'd0) : (rand_bits(4) == 32'd0);
        cur_jr_addr = 16'(rand_bits(8));
        cur_strobe  = 1'b0;
        cur_taken   = 1'b0;
        // Queue as the DUT will see it when these are sampled
        if (m_q.size() > 0) begin
            cur_strobe = quiet ? (rand_bits(5) == 32'd0) : (rand_bits(1) == 32'd1);
            cur_taken  = (rand_bits(2) == 32'd0);
        end
    endtask

    // Whole memory through the load port while fetch is stalled
    task automatic load_program();
        logic [15:0] word;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            word    = make_word();
            prog[i] = word;
            @(posedge CLK);
            load_we   <= 1'b1;
            load_addr <= 16'(i);
            load_data <= word;
        end
        @(posedge CLK);
        load_we <= 1'b0;
    endtask

    initial begin
        RST         = 1'b1;
        stall       = 1'b1;
        jr_valid    = 1'b0;
        jr_addr     = '0;
        resolve     = '0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        lfsr_state  = 32'h0000_f3a6;
        m_pc        = '0;
        m_start     = 1'b1;
        exp_valid   = 1'b0;
        exp_pc      = '0;
        exp_pcplus1 = '0;
        exp_instr   = '0;
        cur_stall   = 1'b1;
        cur_jr      = 1'b0;
        cur_jr_addr = '0;
        cur_strobe  = 1'b0;
        cur_taken   = 1'b0;
        repeat (2) @(posedge CLK);
        RST <= 1'b0;
        load_program();
        // Check at the falling edge and drive at the rising edge
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge CLK);
            compare_fetch();
            model_step();
            pick_stimulus(cyc);
            @(posedge CLK);
            stall    <= cur_stall;
            jr_valid <= cur_jr;
            jr_addr  <= cur_jr_addr;
            resolve  <= '{strobe: cur_strobe, taken: cur_taken};
        end
        @(negedge CLK);
        compare_fetch();
        // Every redirect kind and tracker back-pressure must have occurred
        check_value(32'(n_full_hold > 0), 32'd1, "tracker full stall count nonzero");
        check_value(32'(n_taken > 0), 32'd1, "taken resolve count nonzero");
        check_value(32'(n_jr_taken > 0), 32'd1, "jr over taken count nonzero");
        check_value(32'(n_jump > 0), 32'd1, "jump fetch count nonzero");
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tb.f
design/fe_pkg.sv
design/instr_mem.sv
design/branch_tracker.sv
design/ifetch.sv
design/fetch_frontend.sv
verification/fetch_frontend_sva.sv
verification/fetch_frontend_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench
SIM  := obj_dir/Vfetch_frontend_tb
SRCS := $(wildcard design/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_frontend_tb \
		-f tb.f -o Vfetch_frontend_tb

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
